//--- dma_top.f
+incdir+src
src/dma_pkg.sv
src/dma_csr.sv
src/read_src_fsm.sv
src/dma_fifo.sv
src/write_dest_fsm.sv
src/dma_top.sv
test/dma_top_tb.sv

//--- Makefile
BIN := obj_dir/Vdma_top_tb

.PHONY: run clean

run: $(BIN) test/dma_cases.txt
	./$(BIN)

$(BIN): dma_top.f $(wildcard src/*.sv src/*.svh test/*.sv)
	verilator --binary -j 0 --top-module dma_top_tb -f dma_top.f

clean:
	rm -rf obj_dir

//--- test/dma_cases.txt
# name src_addr dest_addr length b_resp, all numbers in hex
# length is beats minus one; b_resp 0 OKAY, 1 EXOKAY, 2 SLVERR, 3 DECERR
single_beat   00001000 00080000 00 0
four_beats    00002040 00090100 03 0
fifo_depth    00003000 000a0000 0f 1
past_depth    00004008 000b0008 27 0
slverr_stop   00005000 000c0000 07 2
after_slverr  00006000 000d0000 05 0
decerr_stop   00007000 000e0000 10 3
full_burst    00008000 000f0000 ff 1

//--- test/dma_top_tb.sv
// DMA engine testbench

`include "dma_config.svh"

module dma_top_tb import dma_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [31:0] SEED = 32'h2cceed9f;

   logic                   clk;
   logic                   reset_n;
   logic                   csr_wr_valid;
   csr_reg_e               csr_addr;
   logic [`DMA_ADDR_W-1:0] csr_wdata;
   logic                   ar_valid;
   logic                   ar_ready = 1'b0;
   logic [`DMA_ADDR_W-1:0] ar_addr;
   logic [`DMA_LEN_W-1:0]  ar_len;
   logic                   r_valid = 1'b0;
   logic                   r_ready;
   logic [`DMA_DATA_W-1:0] r_data = '0;
   logic                   r_last = 1'b0;
   logic                   aw_valid;
   logic                   aw_ready = 1'b0;
   logic [`DMA_ADDR_W-1:0] aw_addr;
   logic [`DMA_LEN_W-1:0]  aw_len;
   logic                   w_valid;
   logic                   w_ready = 1'b0;
   logic [`DMA_DATA_W-1:0] w_data;
   logic                   w_last;
   logic                   b_valid = 1'b0;
   axi_resp_e              b_resp = OKAY;
   logic                   busy;
   logic                   done;
   logic                   stopped_on_error;

   string                  name_q[$];
   logic [`DMA_ADDR_W-1:0] src_q[$];
   logic [`DMA_ADDR_W-1:0] dest_q[$];
   logic [`DMA_LEN_W-1:0]  len_q[$];
   logic [1:0]             resp_q[$];
   string                  cur_name = "reset";
   logic [`DMA_ADDR_W-1:0] cur_src = '0;
   logic [`DMA_ADDR_W-1:0] cur_dest = '0;
   logic [`DMA_LEN_W-1:0]  cur_len = '0;
   logic [1:0]             cur_resp = 2'b00;
   logic [31:0]            rng = SEED;
   logic [`DMA_ADDR_W-1:0] rd_addr = '0;
   logic                   rd_active = 1'b0;
   logic                   r_hold = 1'b0;
   logic                   b_pending = 1'b0;
   int                     rd_beat = 0;
   int                     rd_len = 0;
   int                     wr_beat = 0;
   int                     limit_cycles = 0;

   dma_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] lcg(input logic [31:0] x);
      return x * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic coin();
      rng = lcg(rng);
      return rng[31] | rng[30]; // high three cycles in four
   endfunction

   // memory contents at base + 8k
   function automatic logic [`DMA_DATA_W-1:0] beat_data(input logic [31:0] base, input int k);
      logic [31:0] w;
      w = lcg((base + 32'(8 * k)) ^ SEED);
      return {w, lcg(w)};
   endfunction

   task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         $display("** Error: %s: %s expected %h actual %h", cur_name, what, exp, act);
         $display("ERRORS FOUND");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic csr_write(input csr_reg_e addr, input logic [`DMA_ADDR_W-1:0] data);
      csr_wr_valid = 1'b1;
      csr_addr     = addr;
      csr_wdata    = data;
      @(negedge clk);
      csr_wr_valid = 1'b0;
   endtask

   // source and destination memory models, handshakes complete on the next rising edge
   always @(negedge clk) begin
      ar_ready = coin();
      aw_ready = coin();
      w_ready  = coin();
      r_valid  = coin();
      if (!rd_active)
         r_valid = 1'b0;
      else if (r_hold)
         r_valid = 1'b1; // beat stays until taken
      r_data    = beat_data(rd_addr, rd_beat);
      r_last    = (rd_beat == rd_len);
      b_valid   = b_pending;
      b_resp    = axi_resp_e'(cur_resp);
      b_pending = 1'b0;
      if (r_valid && r_ready) begin
         rd_beat++;
         if (r_last)
            rd_active = 1'b0;
      end
      r_hold = r_valid && !r_ready;
      if (ar_valid && ar_ready) begin
         check("ar_addr", 64'(cur_src), 64'(ar_addr));
         check("ar_len", 64'(cur_len), 64'(ar_len));
         rd_active = 1'b1;
         rd_addr   = ar_addr;
         rd_len    = int'(ar_len);
         rd_beat   = 0;
      end
      if (aw_valid && aw_ready) begin
         check("aw_addr", 64'(cur_dest), 64'(aw_addr));
         check("aw_len", 64'(cur_len), 64'(aw_len));
         wr_beat = 0;
      end
      if (w_valid && w_ready) begin
         check("w_data", beat_data(cur_src, wr_beat), w_data);
         check("w_last", 64'(wr_beat == int'(cur_len)), 64'(w_last));
         wr_beat++;
         if (w_last)
            b_pending = 1'b1;
      end
   end

   initial begin
      wait (limit_cycles != 0);
      repeat (limit_cycles) @(posedge clk);
      $display("timeout: the transfers did not finish in %0d cycles", limit_cycles);
      $display("ERRORS FOUND");
      $fatal(1, "watchdog expired");
   end

   initial begin
      int                     fd;
      int                     n;
      int                     total;
      string                  tok;
      string                  line;
      logic [`DMA_ADDR_W-1:0] s;
      logic [`DMA_ADDR_W-1:0] d;
      logic [`DMA_LEN_W-1:0]  l;
      logic [1:0]             r;
      reset_n      = 1'b0;
      csr_wr_valid = 1'b0;
      csr_addr     = REG_SRC_ADDR;
      csr_wdata    = '0;
      total        = 0;
      fd = $fopen("test/dma_cases.txt", "r");
      if (fd == 0) begin
         $display("cannot open the case file test/dma_cases.txt");
         $display("ERRORS FOUND");
         $fatal(1, "no case file");
      end
      while ($fscanf(fd, "%s", tok) == 1) begin
         if (tok.substr(0, 0) == "#") begin
            n = $fgets(line, fd); // comment line
         end else begin
            n = $fscanf(fd, "%h %h %h %h", s, d, l, r);
            if (n != 4) begin
               $display("case line %s does not hold four numbers", tok);
               $display("ERRORS FOUND");
               $fatal(1, "bad case line");
            end
            name_q.push_back(tok);
            src_q.push_back(s);
            dest_q.push_back(d);
            len_q.push_back(l);
            resp_q.push_back(r);
            total += int'(l) + 1;
         end
      end
      $fclose(fd);
      if (name_q.size() == 0) begin
         $display("the case file holds no cases");
         $display("ERRORS FOUND");
         $fatal(1, "empty case file");
      end
      limit_cycles = 300 + 40 * total;

      repeat (10) @(posedge clk);
      @(negedge clk);
      reset_n = 1'b1;
      check("busy", 64'(0), 64'(busy));
      check("done", 64'(0), 64'(done));
      check("stopped_on_error", 64'(0), 64'(stopped_on_error));
      check("ar_valid", 64'(0), 64'(ar_valid));
      check("aw_valid", 64'(0), 64'(aw_valid));
      check("w_valid", 64'(0), 64'(w_valid));
      check("r_ready", 64'(0), 64'(r_ready));

      foreach (name_q[i]) begin
         cur_name = name_q[i];
         cur_src  = src_q[i];
         cur_dest = dest_q[i];
         cur_len  = len_q[i];
         cur_resp = resp_q[i];
         csr_write(REG_SRC_ADDR, cur_src);
         csr_write(REG_DEST_ADDR, cur_dest);
         csr_write(REG_LENGTH, 32'(cur_len));
         csr_write(REG_CONTROL, 32'h1);
         while (!busy)
            @(negedge clk);
         csr_write(REG_SRC_ADDR, ~cur_src); // dropped while busy
         csr_write(REG_DEST_ADDR, ~cur_dest);
         csr_write(REG_LENGTH, 32'(~cur_len));
         while (!done && !stopped_on_error)
            @(negedge clk);
         check("r_ready after transfer", 64'(0), 64'(r_ready));
         check("write beats", 64'(int'(cur_len) + 1), 64'(wr_beat));
         check("busy", 64'(0), 64'(busy));
         if (cur_resp < 2'd2) begin
            check("done", 64'(1), 64'(done));
            check("stopped_on_error", 64'(0), 64'(stopped_on_error));
         end else begin
            check("stopped_on_error", 64'(1), 64'(stopped_on_error));
            check("done", 64'(0), 64'(done));
            csr_write(REG_CONTROL, 32'h1);
            repeat (20) begin
               check("ar_valid while stopped", 64'(0), 64'(ar_valid));
               @(negedge clk);
            end
            csr_write(REG_CONTROL, 32'h2);
            repeat (2) @(negedge clk);
            check("stopped_on_error after reset_dispatcher", 64'(0), 64'(stopped_on_error));
         end
      end
      $display("NO ERRORS");
      $finish;
   end

endmodule

//--- src/dma_top.sv
// Single channel DMA engine top

`include "dma_config.svh"

module dma_top import dma_pkg::*; (
   input  logic                   clk,
   input  logic                   reset_n,
   input  logic                   csr_wr_valid,
   input  csr_reg_e               csr_addr,
   input  logic [`DMA_ADDR_W-1:0] csr_wdata,
   output logic                   ar_valid,
   input  logic                   ar_ready,
   output logic [`DMA_ADDR_W-1:0] ar_addr,
   output logic [`DMA_LEN_W-1:0]  ar_len,
   input  logic                   r_valid,
   output logic                   r_ready,
   input  logic [`DMA_DATA_W-1:0] r_data,
   input  logic                   r_last,
   output logic                   aw_valid,
   input  logic                   aw_ready,
   output logic [`DMA_ADDR_W-1:0] aw_addr,
   output logic [`DMA_LEN_W-1:0]  aw_len,
   output logic                   w_valid,
   input  logic                   w_ready,
   output logic [`DMA_DATA_W-1:0] w_data,
   output logic                   w_last,
   input  logic                   b_valid,
   input  axi_resp_e              b_resp,
   output logic                   busy,
   output logic                   done,
   output logic                   stopped_on_error
);

   logic [`DMA_ADDR_W-1:0] src_addr;
   logic [`DMA_ADDR_W-1:0] dest_addr;
   logic [`DMA_LEN_W-1:0]  length;
   logic                   go;
   logic                   reset_dispatcher;
   logic                   wr_fsm_done;
   logic                   wr_fsm_error;
   logic                   push;
   logic [`DMA_DATA_W-1:0] push_data;
   logic                   full;
   logic                   pop;
   logic [`DMA_DATA_W-1:0] pop_data;
   logic                   empty;

   dma_csr u_csr (
      .clk, .reset_n, .csr_wr_valid, .csr_addr, .csr_wdata,
      .src_addr, .dest_addr, .length, .go, .reset_dispatcher,
      .wr_fsm_done, .wr_fsm_error, .busy, .done, .stopped_on_error
   );

   read_src_fsm u_rd (
      .clk, .reset_n, .go, .src_addr, .length,
      .ar_valid, .ar_ready, .ar_addr, .ar_len,
      .r_valid, .r_ready, .r_data, .r_last,
      .push, .push_data, .full
   );

   dma_fifo u_fifo (
      .clk, .reset_n, .push, .push_data, .full, .pop, .pop_data, .empty
   );

   write_dest_fsm u_wr (
      .clk, .reset_n, .go, .dest_addr, .length, .reset_dispatcher,
      .aw_valid, .aw_ready, .aw_addr, .aw_len,
      .w_valid, .w_ready, .w_data, .w_last, .b_valid, .b_resp,
      .pop, .pop_data, .empty, .wr_fsm_done, .wr_fsm_error
   );

endmodule

//--- src/write_dest_fsm.sv
// Destination write burst state machine

`include "dma_config.svh"

module write_dest_fsm import dma_pkg::*; (
   input  logic                   clk,
   input  logic                   reset_n,
   input  logic                   go,
   input  logic [`DMA_ADDR_W-1:0] dest_addr,
   input  logic [`DMA_LEN_W-1:0]  length,
   input  logic                   reset_dispatcher,
   output logic                   aw_valid,
   input  logic                   aw_ready,
   output logic [`DMA_ADDR_W-1:0] aw_addr,
   output logic [`DMA_LEN_W-1:0]  aw_len,
   output logic                   w_valid,
   input  logic                   w_ready,
   output logic [`DMA_DATA_W-1:0] w_data,
   output logic                   w_last,
   input  logic                   b_valid,
   input  axi_resp_e              b_resp,
   output logic                   pop,
   input  logic [`DMA_DATA_W-1:0] pop_data,
   input  logic                   empty,
   output logic                   wr_fsm_done,
   output logic                   wr_fsm_error
);

   wr_state_e             state;
   wr_state_e             next;
   logic [`DMA_LEN_W-1:0] beat_cnt;
   logic                  b_ready;
   logic                  rsp_fire;
   logic                  rsp_ok;

   assign b_ready  = 1'b1; // responses are always taken
   assign rsp_fire = (state == WAIT_FOR_WR_RSP) && b_valid && b_ready;
   assign rsp_ok   = (b_resp == OKAY) || (b_resp == EXOKAY);

   always_ff @(posedge clk) begin
      if (!reset_n)
         state <= IDLE;
      else
         state <= next;
   end

   always_comb begin
      next = state;
      unique case (state)
         IDLE:            if (go) next = ADDR_SETUP;
         ADDR_SETUP:      if (aw_ready) next = RD_FIFO_WR_DEST;
         RD_FIFO_WR_DEST: if (pop && w_last) next = WAIT_FOR_WR_RSP;
         WAIT_FOR_WR_RSP: if (rsp_fire) next = rsp_ok ? IDLE : ERROR;
         ERROR:           if (reset_dispatcher) next = IDLE;
         default:         next = IDLE;
      endcase
   end

   // counts beats accepted on the W channel
   always_ff @(posedge clk) begin
      if (!reset_n)
         beat_cnt <= '0;
      else if (go)
         beat_cnt <= '0;
      else if (pop)
         beat_cnt <= beat_cnt + 1'b1;
   end

   assign aw_valid = (state == ADDR_SETUP);
   assign aw_addr  = dest_addr;
   assign aw_len   = length;

   assign w_valid = (state == RD_FIFO_WR_DEST) && !empty;
   assign w_data  = pop_data;
   assign w_last  = w_valid && (beat_cnt == length);
   assign pop     = w_valid && w_ready;

   assign wr_fsm_done  = rsp_fire && rsp_ok;
   assign wr_fsm_error = rsp_fire && !rsp_ok; // same cycle the machine heads into ERROR

endmodule

//--- src/dma_fifo.sv
// Beat FIFO, first word fall through

`include "dma_config.svh"

module dma_fifo (
   input  logic                   clk,
   input  logic                   reset_n,
   input  logic                   push,
   input  logic [`DMA_DATA_W-1:0] push_data,
   output logic                   full,
   input  logic                   pop,
   output logic [`DMA_DATA_W-1:0] pop_data,
   output logic                   empty
);

   localparam int AW = $clog2(`DMA_FIFO_DEPTH);

   logic [`DMA_DATA_W-1:0] mem [`DMA_FIFO_DEPTH];
   logic [AW-1:0]          wr_ptr;
   logic [AW-1:0]          rd_ptr;
   logic [AW:0]            count;
   logic                   do_push;
   logic                   do_pop;

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1; // wraps at depth
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
      end
   end

   assign full     = (count == (AW+1)'(`DMA_FIFO_DEPTH));
   assign empty    = (count == '0);
   assign pop_data = mem[rd_ptr]; // head is valid whenever not empty

endmodule

//--- src/read_src_fsm.sv
// Source read burst state machine

`include "dma_config.svh"

module read_src_fsm import dma_pkg::*; (
   input  logic                   clk,
   input  logic                   reset_n,
   input  logic                   go,
   input  logic [`DMA_ADDR_W-1:0] src_addr,
   input  logic [`DMA_LEN_W-1:0]  length,
   output logic                   ar_valid,
   input  logic                   ar_ready,
   output logic [`DMA_ADDR_W-1:0] ar_addr,
   output logic [`DMA_LEN_W-1:0]  ar_len,
   input  logic                   r_valid,
   output logic                   r_ready,
   input  logic [`DMA_DATA_W-1:0] r_data,
   input  logic                   r_last,
   output logic                   push,
   output logic [`DMA_DATA_W-1:0] push_data,
   input  logic                   full
);

   rd_state_e state;
   rd_state_e next;

   always_ff @(posedge clk) begin
      if (!reset_n)
         state <= RD_IDLE;
      else
         state <= next;
   end

   always_comb begin
      next = state;
      unique case (state)
         RD_IDLE: begin
            if (go)
               next = RD_ADDR;
         end
         RD_ADDR: begin
            if (ar_ready)
               next = RD_DATA;
         end
         RD_DATA: begin
            if (push && r_last)
               next = RD_IDLE;
         end
         default: next = RD_IDLE;
      endcase
   end

   // descriptor is stable while busy, so the request payload holds
   assign ar_valid = (state == RD_ADDR);
   assign ar_addr  = src_addr;
   assign ar_len   = length;

   assign r_ready   = (state == RD_DATA) && !full; // stall the source when the FIFO fills
   assign push      = r_valid && r_ready;
   assign push_data = r_data;

endmodule

//--- src/dma_csr.sv
// DMA descriptor and control registers

`include "dma_config.svh"

module dma_csr import dma_pkg::*; (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  csr_wr_valid,
   input  csr_reg_e              csr_addr,
   input  logic [`DMA_ADDR_W-1:0] csr_wdata,
   output logic [`DMA_ADDR_W-1:0] src_addr,
   output logic [`DMA_ADDR_W-1:0] dest_addr,
   output logic [`DMA_LEN_W-1:0]  length,
   output logic                  go,
   output logic                  reset_dispatcher,
   input  logic                  wr_fsm_done,
   input  logic                  wr_fsm_error,
   output logic                  busy,
   output logic                  done,
   output logic                  stopped_on_error
);

   logic ctrl_wr;
   logic desc_wr;

   assign ctrl_wr = csr_wr_valid && (csr_addr == REG_CONTROL);
   assign desc_wr = csr_wr_valid && !busy; // descriptor frozen during a transfer

   always_ff @(posedge clk) begin
      if (desc_wr && (csr_addr == REG_SRC_ADDR))
         src_addr <= csr_wdata;
      if (desc_wr && (csr_addr == REG_DEST_ADDR))
         dest_addr <= csr_wdata;
      if (desc_wr && (csr_addr == REG_LENGTH))
         length <= csr_wdata[`DMA_LEN_W-1:0];
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         go               <= 1'b0;
         reset_dispatcher <= 1'b0;
         busy             <= 1'b0;
         done             <= 1'b0;
         stopped_on_error <= 1'b0;
      end else begin
         // !go blocks a second start before busy is up
         go               <= ctrl_wr && csr_wdata[0] && !busy && !go && !stopped_on_error;
         reset_dispatcher <= ctrl_wr && csr_wdata[1];
         if (go)
            busy <= 1'b1;
         else if (wr_fsm_done || wr_fsm_error)
            busy <= 1'b0;
         if (go)
            done <= 1'b0;
         else if (wr_fsm_done)
            done <= 1'b1;
         if (wr_fsm_error)
            stopped_on_error <= 1'b1;
         else if (reset_dispatcher)
            stopped_on_error <= 1'b0;
      end
   end

endmodule

//--- src/dma_pkg.sv
// DMA engine shared types

package dma_pkg;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

   // write machine, one-hot
   typedef enum logic [4:0] {
      IDLE            = 5'b00001,
      ADDR_SETUP      = 5'b00010,
      RD_FIFO_WR_DEST = 5'b00100,
      WAIT_FOR_WR_RSP = 5'b01000,
      ERROR           = 5'b10000
   } wr_state_e;

   typedef enum logic [1:0] {
      RD_IDLE = 2'd0,
      RD_ADDR = 2'd1,
      RD_DATA = 2'd2
   } rd_state_e;

   // control register: bit 0 go, bit 1 reset_dispatcher
   typedef enum logic [1:0] {
      REG_SRC_ADDR  = 2'd0,
      REG_DEST_ADDR = 2'd1,
      REG_LENGTH    = 2'd2,
      REG_CONTROL   = 2'd3
   } csr_reg_e;

endpackage

//--- src/dma_config.svh
// DMA engine widths and depths

`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// byte address width on both memory channels
`define DMA_ADDR_W 32

// one beat of data
`define DMA_DATA_W 64

// burst length field, holds beats minus one
`define DMA_LEN_W 8

// beat buffer between read and write sides, power of two
`define DMA_FIFO_DEPTH 16

`endif
